// File: verilog/core_pkg.sv
`default_nettype none

package core_pkg;

	// dispatch width and register numbering
	localparam int NUM_SLOTS  = 4;
	localparam int WIDTH_ARCH = 5;
	localparam int WIDTH_PRD  = 7;
	localparam int NUM_ARCH   = 1 << WIDTH_ARCH;
	localparam int NUM_PRD    = 1 << WIDTH_PRD;

	// one free list bank per dispatch slot
	localparam int BANK_SIZE  = 32;
	localparam int WIDTH_BPTR = $clog2(BANK_SIZE);

	// tag is {row, slot}
	localparam int ROB_ROWS   = 8;
	localparam int WIDTH_ROW  = $clog2(ROB_ROWS);
	localparam int WIDTH_SLOT = $clog2(NUM_SLOTS);
	localparam int WIDTH_TAG  = WIDTH_ROW + WIDTH_SLOT;

	typedef struct packed {
		logic                  valid;
		logic                  has_rd;
		logic [WIDTH_ARCH-1:0] rd;
		logic [WIDTH_ARCH-1:0] rs1;
		logic [WIDTH_ARCH-1:0] rs2;
	} rename_req_t;

	typedef struct packed {
		logic                 valid;
		logic [WIDTH_PRD-1:0] prd;
		logic [WIDTH_PRD-1:0] prs1;
		logic [WIDTH_PRD-1:0] prs2;
		logic                 p1_ready;
		logic                 p2_ready;
		logic [WIDTH_TAG-1:0] tag;
	} renamed_uop_t;

	typedef struct packed {
		logic                 valid;
		logic [WIDTH_PRD-1:0] prd;
		logic [WIDTH_TAG-1:0] tag;
	} wb_t;

	// freed is the mapping the slot's rd had before it was renamed
	typedef struct packed {
		logic                 valid;
		logic [WIDTH_PRD-1:0] freed;
		logic                 free_en;
	} commit_t;

	typedef enum logic [1:0] {
		EMPTY,
		WAITING,
		DONE
	} rob_state_e;

endpackage

`default_nettype wire

// File: verilog/freelist.sv
`default_nettype none

module freelist #(
	parameter int FIRST = 1,
	parameter int COUNT = core_pkg::BANK_SIZE
) (
	input  wire                            i_clk,
	input  wire                            i_rst_n,
	input  wire                            i_pop,
	input  wire                            i_push,
	input  wire  [core_pkg::WIDTH_PRD-1:0] i_push_prd,
	output logic [core_pkg::WIDTH_PRD-1:0] o_head,
	output logic                           o_empty
);
	import core_pkg::*;

	logic [WIDTH_PRD-1:0]  mem [BANK_SIZE];
	logic [WIDTH_BPTR-1:0] rd_ptr;
	logic [WIDTH_BPTR-1:0] wr_ptr;
	logic [WIDTH_BPTR:0]   count;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			// bank starts out holding its own register range
			for (int i = 0; i < BANK_SIZE; i++) begin
				if (i < COUNT)
					mem[i] <= WIDTH_PRD'(FIRST + i);
			end
			rd_ptr <= '0;
			wr_ptr <= WIDTH_BPTR'(COUNT);
			count  <= (WIDTH_BPTR + 1)'(COUNT);
		end else begin
			if (i_push) begin
				mem[wr_ptr] <= i_push_prd;
				wr_ptr      <= wr_ptr + 1'b1;
			end
			if (i_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({i_push, i_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// head is valid whenever the bank is not empty
	assign o_head  = mem[rd_ptr];
	assign o_empty = (count == '0);

endmodule

`default_nettype wire

// File: verilog/rename_map.sv
`default_nettype none

module rename_map (
	input  wire                             i_clk,
	input  wire                             i_rst_n,
	input  wire                             i_fire,
	input  wire  core_pkg::rename_req_t     i_req     [core_pkg::NUM_SLOTS],
	input  wire  [core_pkg::WIDTH_PRD-1:0]  i_head    [core_pkg::NUM_SLOTS],
	output logic [core_pkg::NUM_SLOTS-1:0]  o_pop,
	output logic [core_pkg::WIDTH_PRD-1:0]  o_prd     [core_pkg::NUM_SLOTS],
	output logic [core_pkg::WIDTH_PRD-1:0]  o_prs1    [core_pkg::NUM_SLOTS],
	output logic [core_pkg::WIDTH_PRD-1:0]  o_prs2    [core_pkg::NUM_SLOTS],
	output logic [core_pkg::WIDTH_PRD-1:0]  o_old_prd [core_pkg::NUM_SLOTS],
	output logic [core_pkg::NUM_SLOTS-1:0]  o_fwd1,
	output logic [core_pkg::NUM_SLOTS-1:0]  o_fwd2
);
	import core_pkg::*;

	logic [WIDTH_PRD-1:0] map [NUM_ARCH];
	logic [NUM_SLOTS-1:0] alloc;

	// x0 is never renamed
	always_comb begin
		for (int s = 0; s < NUM_SLOTS; s++)
			alloc[s] = i_req[s].valid && i_req[s].has_rd && (i_req[s].rd != '0);
	end

	assign o_pop = alloc;

	always_comb begin
		for (int s = 0; s < NUM_SLOTS; s++) begin
			o_prd[s]     = alloc[s] ? i_head[s] : '0;
			o_prs1[s]    = map[i_req[s].rs1];
			o_prs2[s]    = map[i_req[s].rs2];
			o_old_prd[s] = map[i_req[s].rd];
			o_fwd1[s]    = 1'b0;
			o_fwd2[s]    = 1'b0;
			// walk earlier slots in order, so the latest writer wins
			for (int e = 0; e < s; e++) begin
				if (alloc[e] && (i_req[e].rd == i_req[s].rs1)) begin
					o_prs1[s] = i_head[e];
					o_fwd1[s] = 1'b1;
				end
				if (alloc[e] && (i_req[e].rd == i_req[s].rs2)) begin
					o_prs2[s] = i_head[e];
					o_fwd2[s] = 1'b1;
				end
				if (alloc[e] && (i_req[e].rd == i_req[s].rd))
					o_old_prd[s] = i_head[e];
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int a = 0; a < NUM_ARCH; a++)
				map[a] <= '0;
		end else if (i_fire) begin
			// later slots overwrite earlier ones for the same rd
			for (int s = 0; s < NUM_SLOTS; s++) begin
				if (alloc[s])
					map[i_req[s].rd] <= i_head[s];
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/busy_table.sv
`default_nettype none

module busy_table (
	input  wire                              i_clk,
	input  wire                              i_rst_n,
	input  wire  [core_pkg::NUM_SLOTS-1:0]   i_set_en,
	input  wire  [core_pkg::WIDTH_PRD-1:0]   i_set_prd [core_pkg::NUM_SLOTS],
	input  wire  core_pkg::wb_t              i_wb      [core_pkg::NUM_SLOTS],
	input  wire  [core_pkg::WIDTH_PRD-1:0]   i_rd_prd  [2*core_pkg::NUM_SLOTS],
	output logic [2*core_pkg::NUM_SLOTS-1:0] o_busy
);
	import core_pkg::*;

	logic [NUM_PRD-1:0] busy;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			busy <= '0;
		end else begin
			for (int w = 0; w < NUM_SLOTS; w++) begin
				if (i_wb[w].valid)
					busy[i_wb[w].prd] <= 1'b0;
			end
			// p0 stays ready forever
			for (int s = 0; s < NUM_SLOTS; s++) begin
				if (i_set_en[s] && (i_set_prd[s] != '0))
					busy[i_set_prd[s]] <= 1'b1;
			end
		end
	end

	// two source reads per slot
	always_comb begin
		for (int i = 0; i < 2 * NUM_SLOTS; i++)
			o_busy[i] = busy[i_rd_prd[i]];
	end

endmodule

`default_nettype wire

// File: verilog/rob.sv
`default_nettype none

module rob (
	input  wire                            i_clk,
	input  wire                            i_rst_n,
	input  wire                            i_fire,
	input  wire  [core_pkg::NUM_SLOTS-1:0] i_alloc,
	input  wire  [core_pkg::NUM_SLOTS-1:0] i_valid,
	input  wire  [core_pkg::WIDTH_PRD-1:0] i_old_prd [core_pkg::NUM_SLOTS],
	input  wire  core_pkg::wb_t            i_wb      [core_pkg::NUM_SLOTS],
	output logic [core_pkg::WIDTH_ROW-1:0] o_tag_row,
	output logic                           o_full,
	output core_pkg::commit_t              o_commit  [core_pkg::NUM_SLOTS]
);
	import core_pkg::*;

	rob_state_e           state   [ROB_ROWS][NUM_SLOTS];
	logic [WIDTH_PRD-1:0] old_prd [ROB_ROWS][NUM_SLOTS];
	logic [NUM_SLOTS-1:0] alloc   [ROB_ROWS];
	logic [WIDTH_ROW-1:0] head;
	logic [WIDTH_ROW-1:0] tail;
	logic [WIDTH_ROW:0]   count;
	logic                 commit;

	// new group always lands in the tail row
	assign o_tag_row = tail;
	assign o_full    = (count == (WIDTH_ROW + 1)'(ROB_ROWS));

	// head row retires once nothing in it is still waiting
	always_comb begin
		commit = (count != '0);
		for (int s = 0; s < NUM_SLOTS; s++) begin
			if (state[head][s] == WAITING)
				commit = 1'b0;
		end
		for (int s = 0; s < NUM_SLOTS; s++) begin
			o_commit[s].valid   = commit && (state[head][s] != EMPTY);
			o_commit[s].freed   = old_prd[head][s];
			o_commit[s].free_en = commit && (state[head][s] != EMPTY) &&
			                      alloc[head][s] && (old_prd[head][s] != '0);
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int r = 0; r < ROB_ROWS; r++) begin
				for (int s = 0; s < NUM_SLOTS; s++)
					state[r][s] <= EMPTY;
			end
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			// tag upper bits pick the row of each done mark
			for (int w = 0; w < NUM_SLOTS; w++) begin
				if (i_wb[w].valid)
					state[i_wb[w].tag[WIDTH_TAG-1:WIDTH_SLOT]]
					     [i_wb[w].tag[WIDTH_SLOT-1:0]] <= DONE;
			end
			if (commit) begin
				for (int s = 0; s < NUM_SLOTS; s++)
					state[head][s] <= EMPTY;
				head <= head + 1'b1;
			end
			if (i_fire) begin
				for (int s = 0; s < NUM_SLOTS; s++)
					state[tail][s] <= i_valid[s] ? WAITING : EMPTY;
				tail <= tail + 1'b1;
			end
			count <= count + (WIDTH_ROW + 1)'(i_fire) - (WIDTH_ROW + 1)'(commit);
		end
	end

	// old mappings and allocate flags per row
	always_ff @(posedge i_clk) begin
		if (i_fire) begin
			alloc[tail] <= i_alloc;
			for (int s = 0; s < NUM_SLOTS; s++)
				old_prd[tail][s] <= i_old_prd[s];
		end
	end

endmodule

`default_nettype wire

// File: verilog/rename_core.sv
`default_nettype none

module rename_core (
	input  wire                          i_clk,
	input  wire                          i_rst_n,
	input  wire                          i_dis_valid,
	input  wire  core_pkg::rename_req_t  i_req    [core_pkg::NUM_SLOTS],
	input  wire  core_pkg::wb_t          i_wb     [core_pkg::NUM_SLOTS],
	output logic                         o_dis_ready,
	output core_pkg::renamed_uop_t       o_uop    [core_pkg::NUM_SLOTS],
	output core_pkg::commit_t            o_commit [core_pkg::NUM_SLOTS]
);
	import core_pkg::*;

	logic                   fire;
	logic [NUM_SLOTS-1:0]   pop;
	logic [NUM_SLOTS-1:0]   empty;
	logic [NUM_SLOTS-1:0]   req_valid;
	logic [NUM_SLOTS-1:0]   fwd1;
	logic [NUM_SLOTS-1:0]   fwd2;
	logic [WIDTH_PRD-1:0]   bank_head [NUM_SLOTS];
	logic [WIDTH_PRD-1:0]   prd       [NUM_SLOTS];
	logic [WIDTH_PRD-1:0]   prs1      [NUM_SLOTS];
	logic [WIDTH_PRD-1:0]   prs2      [NUM_SLOTS];
	logic [WIDTH_PRD-1:0]   old_prd   [NUM_SLOTS];
	logic [WIDTH_PRD-1:0]   rd_prd    [2*NUM_SLOTS];
	logic [2*NUM_SLOTS-1:0] busy;
	logic [WIDTH_ROW-1:0]   tag_row;
	logic                   rob_full;
	renamed_uop_t           uop_d     [NUM_SLOTS];

	// stall if any allocating slot finds its bank empty
	assign o_dis_ready = !(|(pop & empty)) && !rob_full;
	assign fire        = i_dis_valid && o_dis_ready;

	for (genvar b = 0; b < NUM_SLOTS; b++) begin : g_bank
		// bank 0 leaves out p0
		freelist #(
			.FIRST((b == 0) ? 1 : b * BANK_SIZE),
			.COUNT((b == 0) ? BANK_SIZE - 1 : BANK_SIZE)
		) u_freelist (
			.i_clk     (i_clk),
			.i_rst_n   (i_rst_n),
			.i_pop     (fire && pop[b]),
			.i_push    (o_commit[b].free_en),
			.i_push_prd(o_commit[b].freed),
			.o_head    (bank_head[b]),
			.o_empty   (empty[b])
		);
	end

	rename_map u_rename_map (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_fire   (fire),
		.i_req    (i_req),
		.i_head   (bank_head),
		.o_pop    (pop),
		.o_prd    (prd),
		.o_prs1   (prs1),
		.o_prs2   (prs2),
		.o_old_prd(old_prd),
		.o_fwd1   (fwd1),
		.o_fwd2   (fwd2)
	);

	busy_table u_busy_table (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_set_en (pop & {NUM_SLOTS{fire}}),
		.i_set_prd(prd),
		.i_wb     (i_wb),
		.i_rd_prd (rd_prd),
		.o_busy   (busy)
	);

	rob u_rob (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_fire   (fire),
		.i_alloc  (pop),
		.i_valid  (req_valid),
		.i_old_prd(old_prd),
		.i_wb     (i_wb),
		.o_tag_row(tag_row),
		.o_full   (rob_full),
		.o_commit (o_commit)
	);

	always_comb begin
		for (int s = 0; s < NUM_SLOTS; s++) begin
			req_valid[s]      = i_req[s].valid;
			rd_prd[2*s]       = prs1[s];
			rd_prd[2*s+1]     = prs2[s];
			uop_d[s].valid    = fire && i_req[s].valid;
			uop_d[s].prd      = prd[s];
			uop_d[s].prs1     = prs1[s];
			uop_d[s].prs2     = prs2[s];
			// a producer inside the group is never ready yet
			uop_d[s].p1_ready = !busy[2*s] && !fwd1[s];
			uop_d[s].p2_ready = !busy[2*s+1] && !fwd2[s];
			uop_d[s].tag      = {tag_row, WIDTH_SLOT'(s)};
		end
	end

	always_ff @(posedge i_clk) begin
		for (int s = 0; s < NUM_SLOTS; s++) begin
			o_uop[s] <= uop_d[s];
			if (!i_rst_n)
				o_uop[s].valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: verif/rename_tb.sv
`default_nettype none

module rename_tb;
	import core_pkg::*;

	localparam int PERIOD     = 100;
	localparam int SETTLE     = PERIOD / 4;
	// tests take about 110 cycles
	localparam int MAX_CYCLES = 300;

	logic         clk;
	logic         rst_n;
	logic         dis_valid;
	rename_req_t  req    [NUM_SLOTS];
	wb_t          wb     [NUM_SLOTS];
	logic         dis_ready;
	renamed_uop_t uop    [NUM_SLOTS];
	commit_t      commit [NUM_SLOTS];
	int           cycles = 0;

	// reference model
	int           map_m     [NUM_ARCH];
	int           bank_q    [NUM_SLOTS][$];
	bit           busy_m    [NUM_PRD];
	int           tags_q    [$];
	int           tag_prd   [ROB_ROWS*NUM_SLOTS];
	int           row_old   [ROB_ROWS][NUM_SLOTS];
	bit           row_alloc [ROB_ROWS][NUM_SLOTS];
	bit           row_valid [ROB_ROWS][NUM_SLOTS];
	bit           row_done  [ROB_ROWS][NUM_SLOTS];
	int           head_m;
	int           tail_m;
	int           rows_m;
	renamed_uop_t exp_uop   [NUM_SLOTS];
	bit           exp_alloc [NUM_SLOTS];

	rename_core dut_i (
		.i_clk      (clk),
		.i_rst_n    (rst_n),
		.i_dis_valid(dis_valid),
		.i_req      (req),
		.i_wb       (wb),
		.o_dis_ready(dis_ready),
		.o_uop      (uop),
		.o_commit   (commit)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	end

	function automatic void expect_equal(string name, int got, int exp);
		assert (got == exp) else begin
			$display("FAIL at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endfunction

	function automatic void reset_model();
		for (int a = 0; a < NUM_ARCH; a++)
			map_m[a] = 0;
		for (int p = 0; p < NUM_PRD; p++)
			busy_m[p] = 1'b0;
		for (int b = 0; b < NUM_SLOTS; b++) begin
			bank_q[b].delete();
			// p0 is never handed out
			for (int i = (b == 0) ? 1 : 0; i < BANK_SIZE; i++)
				bank_q[b].push_back(b * BANK_SIZE + i);
		end
		tags_q.delete();
		head_m = 0;
		tail_m = 0;
		rows_m = 0;
	endfunction

	function automatic bit allocates(int s);
		return req[s].valid && req[s].has_rd && (req[s].rd != '0);
	endfunction

	function automatic bit bank_and_rob_ready();
		bit ok;
		ok = (rows_m < ROB_ROWS);
		for (int s = 0; s < NUM_SLOTS; s++) begin
			if (allocates(s) && bank_q[s].size() == 0)
				ok = 1'b0;
		end
		return ok;
	endfunction

	// latest earlier slot of the group that writes arch, or -1
	function automatic int latest_writer(int s, logic [WIDTH_ARCH-1:0] arch);
		for (int e = s - 1; e >= 0; e--) begin
			if (allocates(e) && req[e].rd == arch)
				return e;
		end
		return -1;
	endfunction

	function automatic void predict_group();
		int new_prd [NUM_SLOTS];
		int w1;
		int w2;
		int wd;
		int tag;
		for (int s = 0; s < NUM_SLOTS; s++)
			new_prd[s] = allocates(s) ? bank_q[s][0] : 0;
		for (int s = 0; s < NUM_SLOTS; s++) begin
			w1  = latest_writer(s, req[s].rs1);
			w2  = latest_writer(s, req[s].rs2);
			wd  = latest_writer(s, req[s].rd);
			tag = tail_m * NUM_SLOTS + s;
			exp_alloc[s]        = allocates(s);
			exp_uop[s].valid    = req[s].valid;
			exp_uop[s].prd      = WIDTH_PRD'(new_prd[s]);
			exp_uop[s].prs1     = WIDTH_PRD'((w1 >= 0) ? new_prd[w1] : map_m[req[s].rs1]);
			exp_uop[s].prs2     = WIDTH_PRD'((w2 >= 0) ? new_prd[w2] : map_m[req[s].rs2]);
			exp_uop[s].p1_ready = (w1 < 0) && !busy_m[map_m[req[s].rs1]];
			exp_uop[s].p2_ready = (w2 < 0) && !busy_m[map_m[req[s].rs2]];
			exp_uop[s].tag      = WIDTH_TAG'(tag);
			row_old[tail_m][s]   = (wd >= 0) ? new_prd[wd] : map_m[req[s].rd];
			row_alloc[tail_m][s] = allocates(s);
			row_valid[tail_m][s] = req[s].valid;
			row_done[tail_m][s]  = 1'b0;
			tag_prd[tag]         = new_prd[s];
			if (req[s].valid)
				tags_q.push_back(tag);
		end
		// walk in slot order so a later writer of the same rd wins
		for (int s = 0; s < NUM_SLOTS; s++) begin
			if (allocates(s)) begin
				map_m[req[s].rd]   = new_prd[s];
				busy_m[new_prd[s]] = 1'b1;
				void'(bank_q[s].pop_front());
			end
		end
		tail_m = (tail_m + 1) % ROB_ROWS;
		rows_m++;
	endfunction

	function automatic bit compare_commit();
		bit fires;
		bit frees;
		fires = (rows_m > 0);
		for (int s = 0; s < NUM_SLOTS; s++) begin
			if (row_valid[head_m][s] && !row_done[head_m][s])
				fires = 1'b0;
		end
		for (int s = 0; s < NUM_SLOTS; s++) begin
			frees = fires && row_valid[head_m][s] && row_alloc[head_m][s] &&
			        (row_old[head_m][s] != 0);
			expect_equal($sformatf("o_commit[%0d].valid", s), int'(commit[s].valid),
			             int'(fires && row_valid[head_m][s]));
			expect_equal($sformatf("o_commit[%0d].free_en", s), int'(commit[s].free_en),
			             int'(frees));
			if (frees)
				expect_equal($sformatf("o_commit[%0d].freed", s), int'(commit[s].freed),
				             row_old[head_m][s]);
		end
		return fires;
	endfunction

	function automatic void retire_head_row();
		for (int s = 0; s < NUM_SLOTS; s++) begin
			if (row_valid[head_m][s] && row_alloc[head_m][s] && row_old[head_m][s] != 0)
				bank_q[s].push_back(row_old[head_m][s]);
		end
		head_m = (head_m + 1) % ROB_ROWS;
		rows_m--;
	endfunction

	function automatic void note_writebacks();
		int t;
		for (int w = 0; w < NUM_SLOTS; w++) begin
			if (wb[w].valid) begin
				t = int'(wb[w].tag);
				busy_m[wb[w].prd] = 1'b0;
				row_done[t / NUM_SLOTS][t % NUM_SLOTS] = 1'b1;
				for (int i = 0; i < tags_q.size(); i++) begin
					if (tags_q[i] == t) begin
						tags_q.delete(i);
						break;
					end
				end
			end
		end
	endfunction

	// one clock with the inputs driven at the current falling edge
	task automatic run_cycle(output bit taken);
		bit fires;
		#(SETTLE);
		fires = compare_commit();
		expect_equal("o_dis_ready", int'(dis_ready), int'(bank_and_rob_ready()));
		taken = dis_valid && bank_and_rob_ready();
		if (taken)
			predict_group();
		if (fires)
			retire_head_row();
		note_writebacks();
		@(negedge clk);
		for (int s = 0; s < NUM_SLOTS; s++) begin
			expect_equal($sformatf("o_uop[%0d].valid", s), int'(uop[s].valid),
			             int'(taken && req[s].valid));
			if (taken && req[s].valid) begin
				if (exp_alloc[s])
					expect_equal($sformatf("o_uop[%0d].prd", s), int'(uop[s].prd),
					             int'(exp_uop[s].prd));
				expect_equal($sformatf("o_uop[%0d].prs1", s), int'(uop[s].prs1),
				             int'(exp_uop[s].prs1));
				expect_equal($sformatf("o_uop[%0d].prs2", s), int'(uop[s].prs2),
				             int'(exp_uop[s].prs2));
				expect_equal($sformatf("o_uop[%0d].p1_ready", s), int'(uop[s].p1_ready),
				             int'(exp_uop[s].p1_ready));
				expect_equal($sformatf("o_uop[%0d].p2_ready", s), int'(uop[s].p2_ready),
				             int'(exp_uop[s].p2_ready));
				expect_equal($sformatf("o_uop[%0d].tag", s), int'(uop[s].tag),
				             int'(exp_uop[s].tag));
			end
			wb[s] = '0;
		end
		if (taken)
			dis_valid = 1'b0;
	endtask

	task automatic clear_group();
		for (int s = 0; s < NUM_SLOTS; s++)
			req[s] = '0;
	endtask

	task automatic set_slot(int s, bit has_rd, int rd, int rs1, int rs2);
		req[s].valid  = 1'b1;
		req[s].has_rd = has_rd;
		req[s].rd     = WIDTH_ARCH'(rd);
		req[s].rs1    = WIDTH_ARCH'(rs1);
		req[s].rs2    = WIDTH_ARCH'(rs2);
	endtask

	// offer the group until the DUT takes it
	task automatic dispatch();
		bit taken;
		dis_valid = 1'b1;
		taken     = 1'b0;
		while (!taken)
			run_cycle(taken);
	endtask

	// oldest n outstanding tags complete in one cycle
	task automatic write_back(int n);
		bit taken;
		int t;
		for (int w = 0; w < n; w++) begin
			if (w < tags_q.size()) begin
				t = tags_q[w];
				wb[w].valid = 1'b1;
				wb[w].tag   = WIDTH_TAG'(t);
				wb[w].prd   = WIDTH_PRD'(tag_prd[t]);
			end
		end
		run_cycle(taken);
	endtask

	task automatic drain();
		bit taken;
		while (tags_q.size() > 0)
			write_back(NUM_SLOTS);
		while (rows_m > 0)
			run_cycle(taken);
	endtask

	task automatic first_group_gets_bank_heads();
		clear_group();
		for (int s = 0; s < NUM_SLOTS; s++)
			set_slot(s, 1'b1, s + 1, 2 * s + 5, 2 * s + 6);
		dispatch();
		expect_equal("o_uop[0].prd", int'(uop[0].prd), 1);
		for (int s = 1; s < NUM_SLOTS; s++)
			expect_equal($sformatf("o_uop[%0d].prd", s), int'(uop[s].prd), s * BANK_SIZE);
		for (int s = 0; s < NUM_SLOTS; s++) begin
			expect_equal($sformatf("o_uop[%0d].prs1", s), int'(uop[s].prs1), 0);
			expect_equal($sformatf("o_uop[%0d].prs2", s), int'(uop[s].prs2), 0);
			expect_equal($sformatf("o_uop[%0d].p1_ready", s), int'(uop[s].p1_ready), 1);
			expect_equal($sformatf("o_uop[%0d].p2_ready", s), int'(uop[s].p2_ready), 1);
			expect_equal($sformatf("o_uop[%0d].tag", s), int'(uop[s].tag), s);
		end
	endtask

	task automatic forwarding_inside_group();
		int first_prd;
		int later_prd;
		clear_group();
		set_slot(0, 1'b1, 5, 1, 0);
		set_slot(1, 1'b1, 6, 5, 2);
		set_slot(2, 1'b1, 5, 6, 5);
		set_slot(3, 1'b1, 7, 5, 6);
		// slots 0 and 2 both write x5 and take their bank heads
		first_prd = bank_q[0][0];
		later_prd = bank_q[2][0];
		dispatch();
		expect_equal("o_uop[1].prs1", int'(uop[1].prs1), first_prd);
		expect_equal("o_uop[1].p1_ready", int'(uop[1].p1_ready), 0);
		expect_equal("o_uop[3].prs1", int'(uop[3].prs1), later_prd);
		expect_equal("o_uop[3].p1_ready", int'(uop[3].p1_ready), 0);
		clear_group();
		set_slot(0, 1'b1, 8, 5, 0);
		dispatch();
		expect_equal("o_uop[0].prs1", int'(uop[0].prs1), later_prd);
	endtask

	task automatic ready_after_writeback();
		drain();
		clear_group();
		set_slot(0, 1'b1, 9, 0, 0);
		set_slot(1, 1'b1, 10, 0, 0);
		dispatch();
		// only the x9 producer completes
		write_back(1);
		clear_group();
		set_slot(0, 1'b1, 11, 9, 10);
		dispatch();
		expect_equal("o_uop[0].p1_ready", int'(uop[0].p1_ready), 1);
		expect_equal("o_uop[0].p2_ready", int'(uop[0].p2_ready), 0);
	endtask

	task automatic commit_returns_registers();
		bit taken;
		int old1;
		int old2;
		drain();
		old1 = map_m[1];
		old2 = map_m[2];
		clear_group();
		set_slot(0, 1'b1, 1, 0, 0);
		set_slot(1, 1'b1, 13, 0, 0);
		set_slot(2, 1'b0, 0, 1, 0);
		set_slot(3, 1'b1, 2, 0, 0);
		dispatch();
		write_back(NUM_SLOTS);
		// row commit shows once its done marks are registered
		expect_equal("o_commit[0].free_en", int'(commit[0].free_en), 1);
		expect_equal("o_commit[0].freed", int'(commit[0].freed), old1);
		expect_equal("o_commit[1].valid", int'(commit[1].valid), 1);
		expect_equal("o_commit[1].free_en", int'(commit[1].free_en), 0);
		expect_equal("o_commit[2].free_en", int'(commit[2].free_en), 0);
		expect_equal("o_commit[3].freed", int'(commit[3].freed), old2);
		run_cycle(taken);
		clear_group();
		while (bank_q[0][0] != old1) begin
			set_slot(0, 1'b1, 20, 0, 0);
			dispatch();
			write_back(1);
		end
		set_slot(0, 1'b1, 3, 0, 0);
		dispatch();
		expect_equal("o_uop[0].prd", int'(uop[0].prd), old1);
	endtask

	task automatic backpressure_holds_group();
		bit taken;
		int head_row;
		drain();
		clear_group();
		for (int g = 0; g < ROB_ROWS; g++) begin
			set_slot(0, 1'b1, 21 + g, 0, 0);
			dispatch();
		end
		head_row = head_m;
		set_slot(0, 1'b1, 30, 21, 0);
		dis_valid = 1'b1;
		run_cycle(taken);
		expect_equal("o_uop[0].valid", int'(uop[0].valid), 0);
		expect_equal("o_dis_ready", int'(dis_ready), 0);
		// group stays offered while the head row completes
		write_back(1);
		dispatch();
		expect_equal("o_uop[0].valid", int'(uop[0].valid), 1);
		expect_equal("o_uop[0].tag", int'(uop[0].tag), head_row * NUM_SLOTS);
	endtask

	initial begin
		rst_n     = 1'b0;
		dis_valid = 1'b0;
		clear_group();
		for (int w = 0; w < NUM_SLOTS; w++)
			wb[w] = '0;
		reset_model();
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		for (int s = 0; s < NUM_SLOTS; s++) begin
			expect_equal($sformatf("o_uop[%0d].valid", s), int'(uop[s].valid), 0);
			expect_equal($sformatf("o_commit[%0d].valid", s), int'(commit[s].valid), 0);
		end
		first_group_gets_bank_heads();
		forwarding_inside_group();
		ready_after_writeback();
		commit_returns_registers();
		backpressure_holds_group();
		drain();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
verilog/core_pkg.sv
verilog/freelist.sv
verilog/rename_map.sv
verilog/busy_table.sv
verilog/rob.sv
verilog/rename_core.sv
verif/rename_tb.sv

// File: Makefile
TOP := rename_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f build.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir
